/* include/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// associativity of the data cache
`define DC_WAYS 2

// 64 sets, one 32-bit word per line
`define DC_IDX_BITS 6

// address bits 31..8, must equal 32 - DC_IDX_BITS - 2
`define DC_TAG_BITS 24

// addresses with this bit set bypass the arrays
`define DC_UNCACHED_BIT 31

`endif

/* source/dcache_pkg.sv */
package dcache_pkg;

  // memory stage operation
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_LOAD  = 2'd1,
    OP_STORE = 2'd2,
    OP_INV   = 2'd3
  } lsu_op_e;

  // load result format
  typedef enum logic [2:0] {
    LT_LB  = 3'd0,
    LT_LBU = 3'd1,
    LT_LH  = 3'd2,
    LT_LHU = 3'd3,
    LT_LW  = 3'd4
  } load_type_e;

  // stage 2 miss handling
  typedef enum logic [2:0] {
    MS_IDLE       = 3'd0,
    MS_REFILL     = 3'd1,
    MS_UNC_READ   = 3'd2,
    MS_BUS_WRITE  = 3'd3,
    MS_INVALIDATE = 3'd4,
    MS_DONE       = 3'd5
  } miss_state_e;

endpackage

/* source/load_align.sv */
`timescale 1ns/10ps

module load_align
  import dcache_pkg::*;
(
  input  logic [31:0] word_i,
  input  logic [1:0]  addr_i,
  input  load_type_e  type_i,
  input  logic        valid_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  logic [31:0] shifted;

  // addressed byte lands in lane 0
  assign shifted = word_i >> {addr_i, 3'b000};

  always_comb begin
    case (type_i)
      LT_LB:   rdata_o = {{24{shifted[7]}}, shifted[7:0]};
      LT_LBU:  rdata_o = {24'h0, shifted[7:0]};
      LT_LH:   rdata_o = {{16{shifted[15]}}, shifted[15:0]};
      LT_LHU:  rdata_o = {16'h0, shifted[15:0]};
      default: rdata_o = shifted;
    endcase
  end

  assign rvalid_o = valid_i;

  // misaligned loads are the requester's fault, no split access here
  always_comb begin
    if (valid_i) begin
      assert ((type_i != LT_LH && type_i != LT_LHU) || !addr_i[0])
        else $error("load_align: halfword load at offset %0d", addr_i);
      assert (type_i != LT_LW || addr_i == 2'b00)
        else $error("load_align: word load at offset %0d", addr_i);
    end
  end

endmodule

/* source/dcache_lookup.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_lookup
  import dcache_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_valid_i,
  input  lsu_op_e                 req_op_i,
  input  logic [31:0]             req_addr_i,
  input  logic [31:0]             req_wdata_i,
  input  logic [3:0]              req_strobe_i,
  input  load_type_e              req_type_i,
  input  logic                    stall_i,
  input  logic                    wr_en_i,
  input  logic [`DC_WAYS-1:0]     wr_way_i,
  input  logic [`DC_IDX_BITS-1:0] wr_idx_i,
  input  logic [`DC_TAG_BITS-1:0] wr_tag_i,
  input  logic                    wr_valid_i,
  input  logic [31:0]             wr_data_i,
  input  logic [3:0]              wr_strobe_i,
  output logic                    s2_valid_o,
  output lsu_op_e                 s2_op_o,
  output logic [31:0]             s2_addr_o,
  output logic [31:0]             s2_wdata_o,
  output logic [3:0]              s2_strobe_o,
  output load_type_e              s2_type_o,
  output logic [`DC_WAYS-1:0]     s2_hit_o,
  output logic [31:0]             s2_hit_data_o
);

  localparam int sets    = 1 << `DC_IDX_BITS;
  localparam int tag_lsb = 32 - `DC_TAG_BITS;

  logic [`DC_WAYS-1:0][sets-1:0] valid_q;
  logic [`DC_TAG_BITS-1:0]       tag_mem [`DC_WAYS][sets];
  logic [31:0]                   data_mem [`DC_WAYS][sets];

  logic                    wb_en_q;
  logic [`DC_WAYS-1:0]     wb_way_q;
  logic [`DC_IDX_BITS-1:0] wb_idx_q;
  logic [`DC_TAG_BITS-1:0] wb_tag_q;
  logic                    wb_valid_q;
  logic [31:0]             wb_data_q;
  logic [3:0]              wb_strobe_q;

  logic       s1_valid_q;
  lsu_op_e    s1_op_q;
  logic [31:0] s1_addr_q;
  logic [31:0] s1_wdata_q;
  logic [3:0] s1_strobe_q;
  load_type_e s1_type_q;

  logic [`DC_WAYS-1:0]     rd_valid_q;
  logic [`DC_TAG_BITS-1:0] rd_tag_q [`DC_WAYS];
  logic [31:0]             rd_data_q [`DC_WAYS];
  logic [`DC_WAYS-1:0]     fwd_valid;
  logic [`DC_TAG_BITS-1:0] fwd_tag [`DC_WAYS];
  logic [31:0]             fwd_data [`DC_WAYS];

  logic [`DC_IDX_BITS-1:0] req_idx;
  logic [`DC_IDX_BITS-1:0] s1_idx;
  logic [`DC_WAYS-1:0]     s1_hit;
  logic [31:0]             s1_hit_data;

  logic       s2_valid_q;
  lsu_op_e    s2_op_q;
  logic [31:0] s2_addr_q;
  logic [31:0] s2_wdata_q;
  logic [3:0] s2_strobe_q;
  load_type_e s2_type_q;
  logic [`DC_WAYS-1:0] s2_hit_q;
  logic [31:0] s2_hit_data_q;

  assign req_idx = req_addr_i[`DC_IDX_BITS+1:2];
  assign s1_idx  = s1_addr_q[`DC_IDX_BITS+1:2];

  // one write port feeds valid, tag and data of every selected way
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (wr_way_i[w]) begin
          valid_q[w][wr_idx_i] <= wr_valid_i;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (wr_way_i[w]) begin
          tag_mem[w][wr_idx_i] <= wr_tag_i;
          for (int b = 0; b < 4; b++) begin
            if (wr_strobe_i[b]) begin
              data_mem[w][wr_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
            end
          end
        end
      end
    end
  end

  // copy of the write that landed on the last edge, the array read missed it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_en_q <= 1'b0;
    end else begin
      wb_en_q <= wr_en_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_way_q    <= wr_way_i;
    wb_idx_q    <= wr_idx_i;
    wb_tag_q    <= wr_tag_i;
    wb_valid_q  <= wr_valid_i;
    wb_data_q   <= wr_data_i;
    wb_strobe_q <= wr_strobe_i;
  end

  // lookup stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else if (!stall_i) begin
      s1_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      s1_op_q     <= req_op_i;
      s1_addr_q   <= req_addr_i;
      s1_wdata_q  <= req_wdata_i;
      s1_strobe_q <= req_strobe_i;
      s1_type_q   <= req_type_i;
    end
  end

  // array read, frozen on the forwarded view while stalled
  always_ff @(posedge clk) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (!stall_i) begin
        rd_valid_q[w] <= valid_q[w][req_idx];
        rd_tag_q[w]   <= tag_mem[w][req_idx];
        rd_data_q[w]  <= data_mem[w][req_idx];
      end else begin
        rd_valid_q[w] <= fwd_valid[w];
        rd_tag_q[w]   <= fwd_tag[w];
        rd_data_q[w]  <= fwd_data[w];
      end
    end
  end

  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      fwd_valid[w] = rd_valid_q[w];
      fwd_tag[w]   = rd_tag_q[w];
      fwd_data[w]  = rd_data_q[w];
      if (wb_en_q && wb_way_q[w] && wb_idx_q == s1_idx) begin
        fwd_valid[w] = wb_valid_q;
        fwd_tag[w]   = wb_tag_q;
        for (int b = 0; b < 4; b++) begin
          if (wb_strobe_q[b]) begin
            fwd_data[w][8*b +: 8] = wb_data_q[8*b +: 8];
          end
        end
      end
      // write in flight wins over the older one
      if (wr_en_i && wr_way_i[w] && wr_idx_i == s1_idx) begin
        fwd_valid[w] = wr_valid_i;
        fwd_tag[w]   = wr_tag_i;
        for (int b = 0; b < 4; b++) begin
          if (wr_strobe_i[b]) begin
            fwd_data[w][8*b +: 8] = wr_data_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    s1_hit_data = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      s1_hit[w] = fwd_valid[w] && (fwd_tag[w] == s1_addr_q[31:tag_lsb]) &&
                  !s1_addr_q[`DC_UNCACHED_BIT];
      s1_hit_data = s1_hit_data | (s1_hit[w] ? fwd_data[w] : 32'h0);
    end
  end

  // decision stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s2_valid_q <= 1'b0;
    end else if (!stall_i) begin
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      s2_op_q       <= s1_op_q;
      s2_addr_q     <= s1_addr_q;
      s2_wdata_q    <= s1_wdata_q;
      s2_strobe_q   <= s1_strobe_q;
      s2_type_q     <= s1_type_q;
      s2_hit_q      <= s1_hit;
      s2_hit_data_q <= s1_hit_data;
    end
  end

  assign s2_valid_o    = s2_valid_q;
  assign s2_op_o       = s2_op_q;
  assign s2_addr_o     = s2_addr_q;
  assign s2_wdata_o    = s2_wdata_q;
  assign s2_strobe_o   = s2_strobe_q;
  assign s2_type_o     = s2_type_q;
  assign s2_hit_o      = s2_hit_q;
  assign s2_hit_data_o = s2_hit_data_q;

  // refill only picks a victim on a miss, so a word lives in one way at most
  a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    s2_valid_q |-> $onehot0(s2_hit_q));

endmodule

/* source/dcache_miss_ctrl.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_miss_ctrl
  import dcache_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    s2_valid_i,
  input  lsu_op_e                 s2_op_i,
  input  logic [31:0]             s2_addr_i,
  input  logic [31:0]             s2_wdata_i,
  input  logic [3:0]              s2_strobe_i,
  input  load_type_e              s2_type_i,
  input  logic [`DC_WAYS-1:0]     s2_hit_i,
  input  logic [31:0]             s2_hit_data_i,
  input  logic [31:0]             prdata_i,
  input  logic                    pready_i,
  input  logic                    pslverr_i,
  output logic                    stall_o,
  output logic                    busy_o,
  output logic                    wr_en_o,
  output logic [`DC_WAYS-1:0]     wr_way_o,
  output logic [`DC_IDX_BITS-1:0] wr_idx_o,
  output logic [`DC_TAG_BITS-1:0] wr_tag_o,
  output logic                    wr_valid_o,
  output logic [31:0]             wr_data_o,
  output logic [3:0]              wr_strobe_o,
  output logic [31:0]             res_word_o,
  output logic [1:0]              res_addr_o,
  output load_type_e              res_type_o,
  output logic                    res_valid_o,
  output logic                    psel_o,
  output logic                    penable_o,
  output logic                    pwrite_o,
  output logic [31:0]             paddr_o,
  output logic [31:0]             pwdata_o,
  output logic [3:0]              pstrb_o
);

  localparam int vic_bits = (`DC_WAYS > 1) ? $clog2(`DC_WAYS) : 1;
  localparam int tag_lsb  = 32 - `DC_TAG_BITS;

  miss_state_e         state_q;
  miss_state_e         state_d;
  logic                penable_q;
  logic [vic_bits-1:0] victim_q;
  logic [31:0]         bus_rdata_q;
  logic                busy;
  logic                in_bus;
  logic                bus_done;
  logic                refill_wr;

  assign in_bus    = state_q inside {MS_REFILL, MS_UNC_READ, MS_BUS_WRITE};
  assign bus_done  = in_bus && penable_q && pready_i;
  assign refill_wr = (state_q == MS_REFILL) && bus_done && !pslverr_i;

  // decision happens in IDLE, busy goes up in that same cycle
  always_comb begin
    state_d = state_q;
    busy    = 1'b0;
    case (state_q)
      MS_IDLE: begin
        if (s2_valid_i) begin
          case (s2_op_i)
            OP_LOAD: begin
              if (s2_addr_i[`DC_UNCACHED_BIT]) begin
                state_d = MS_UNC_READ;
              end else if (!(|s2_hit_i)) begin
                state_d = MS_REFILL;
              end
            end
            // write-through, every store goes out on the bus
            OP_STORE: state_d = MS_BUS_WRITE;
            OP_INV:   state_d = MS_INVALIDATE;
            default:  state_d = MS_IDLE;
          endcase
          busy = (state_d != MS_IDLE);
        end
      end
      MS_REFILL, MS_UNC_READ, MS_BUS_WRITE: begin
        busy = 1'b1;
        if (bus_done) begin
          state_d = MS_DONE;
        end
      end
      MS_INVALIDATE: begin
        busy    = 1'b1;
        state_d = MS_DONE;
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= MS_IDLE;
      penable_q <= 1'b0;
      victim_q  <= '0;
    end else begin
      state_q <= state_d;
      if (bus_done) begin
        penable_q <= 1'b0;
      end else if (in_bus) begin
        penable_q <= 1'b1;
      end
      if (refill_wr) begin
        victim_q <= victim_q + 1'b1;
      end
    end
  end

  // error response reads as zero
  always_ff @(posedge clk) begin
    if (bus_done) begin
      bus_rdata_q <= pslverr_i ? 32'h0 : prdata_i;
    end
  end

  always_comb begin
    wr_en_o     = 1'b0;
    wr_way_o    = '0;
    wr_valid_o  = 1'b1;
    wr_data_o   = s2_wdata_i;
    wr_strobe_o = s2_strobe_i;
    case (state_q)
      MS_IDLE: begin
        // store hit updates only the ways that hold the word
        if (s2_valid_i && s2_op_i == OP_STORE && (|s2_hit_i)) begin
          wr_en_o  = 1'b1;
          wr_way_o = s2_hit_i;
        end
      end
      MS_REFILL: begin
        if (refill_wr) begin
          wr_en_o            = 1'b1;
          wr_way_o[victim_q] = 1'b1;
          wr_data_o          = prdata_i;
          wr_strobe_o        = 4'hf;
        end
      end
      MS_INVALIDATE: begin
        wr_en_o     = 1'b1;
        wr_way_o    = '1;
        wr_valid_o  = 1'b0;
        wr_strobe_o = 4'h0;
      end
      default: wr_en_o = 1'b0;
    endcase
  end

  assign wr_idx_o = s2_addr_i[`DC_IDX_BITS+1:2];
  assign wr_tag_o = s2_addr_i[31:tag_lsb];

  assign stall_o = busy;
  assign busy_o  = busy;

  // hit result in IDLE, bus result in DONE
  assign res_word_o  = (state_q == MS_DONE) ? bus_rdata_q : s2_hit_data_i;
  assign res_addr_o  = s2_addr_i[1:0];
  assign res_type_o  = s2_type_i;
  assign res_valid_o = s2_valid_i && (s2_op_i == OP_LOAD) &&
                       ((state_q == MS_IDLE && !busy) || state_q == MS_DONE);

  assign psel_o    = in_bus;
  assign penable_o = penable_q;
  assign pwrite_o  = (state_q == MS_BUS_WRITE);
  assign paddr_o   = (state_q == MS_REFILL) ? {s2_addr_i[31:2], 2'b00} : s2_addr_i;
  assign pwdata_o  = s2_wdata_i;
  assign pstrb_o   = pwrite_o ? s2_strobe_i : 4'h0;

  a_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
    penable_o |-> $past(psel_o));

  // stage 2 is stalled, so the request fields feeding APB cannot move
  a_apb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (psel_o && penable_o && !pready_i) |=>
      (psel_o && penable_o && $stable(paddr_o) && $stable(pwrite_o) &&
       $stable(pwdata_o) && $stable(pstrb_o)));

endmodule

/* source/dcache_lsu.sv */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_lsu
  import dcache_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_valid_i,
  input  lsu_op_e     req_op_i,
  input  logic [31:0] req_addr_i,
  input  logic [31:0] req_wdata_i,
  input  logic [3:0]  req_strobe_i,
  input  load_type_e  req_type_i,
  output logic        busy_o,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  output logic        psel_o,
  output logic        penable_o,
  output logic        pwrite_o,
  output logic [31:0] paddr_o,
  output logic [31:0] pwdata_o,
  output logic [3:0]  pstrb_o,
  input  logic [31:0] prdata_i,
  input  logic        pready_i,
  input  logic        pslverr_i
);

  // stage 2 request from lookup
  logic                    s2_valid;
  lsu_op_e                 s2_op;
  logic [31:0]             s2_addr;
  logic [31:0]             s2_wdata;
  logic [3:0]              s2_strobe;
  load_type_e              s2_type;
  logic [`DC_WAYS-1:0]     s2_hit;
  logic [31:0]             s2_hit_data;

  // array write port back into lookup
  logic                    wr_en;
  logic [`DC_WAYS-1:0]     wr_way;
  logic [`DC_IDX_BITS-1:0] wr_idx;
  logic [`DC_TAG_BITS-1:0] wr_tag;
  logic                    wr_valid;
  logic [31:0]             wr_data;
  logic [3:0]              wr_strobe;
  logic                    stall;

  logic [31:0]             res_word;
  logic [1:0]              res_addr;
  load_type_e              res_type;
  logic                    res_valid;

  dcache_lookup u_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .req_strobe_i  (req_strobe_i),
    .req_type_i    (req_type_i),
    .stall_i       (stall),
    .wr_en_i       (wr_en),
    .wr_way_i      (wr_way),
    .wr_idx_i      (wr_idx),
    .wr_tag_i      (wr_tag),
    .wr_valid_i    (wr_valid),
    .wr_data_i     (wr_data),
    .wr_strobe_i   (wr_strobe),
    .s2_valid_o    (s2_valid),
    .s2_op_o       (s2_op),
    .s2_addr_o     (s2_addr),
    .s2_wdata_o    (s2_wdata),
    .s2_strobe_o   (s2_strobe),
    .s2_type_o     (s2_type),
    .s2_hit_o      (s2_hit),
    .s2_hit_data_o (s2_hit_data)
  );

  dcache_miss_ctrl u_miss_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .s2_valid_i    (s2_valid),
    .s2_op_i       (s2_op),
    .s2_addr_i     (s2_addr),
    .s2_wdata_i    (s2_wdata),
    .s2_strobe_i   (s2_strobe),
    .s2_type_i     (s2_type),
    .s2_hit_i      (s2_hit),
    .s2_hit_data_i (s2_hit_data),
    .prdata_i      (prdata_i),
    .pready_i      (pready_i),
    .pslverr_i     (pslverr_i),
    .stall_o       (stall),
    .busy_o        (busy_o),
    .wr_en_o       (wr_en),
    .wr_way_o      (wr_way),
    .wr_idx_o      (wr_idx),
    .wr_tag_o      (wr_tag),
    .wr_valid_o    (wr_valid),
    .wr_data_o     (wr_data),
    .wr_strobe_o   (wr_strobe),
    .res_word_o    (res_word),
    .res_addr_o    (res_addr),
    .res_type_o    (res_type),
    .res_valid_o   (res_valid),
    .psel_o        (psel_o),
    .penable_o     (penable_o),
    .pwrite_o      (pwrite_o),
    .paddr_o       (paddr_o),
    .pwdata_o      (pwdata_o),
    .pstrb_o       (pstrb_o)
  );

  load_align u_align (
    .word_i   (res_word),
    .addr_i   (res_addr),
    .type_i   (res_type),
    .valid_i  (res_valid),
    .rdata_o  (rdata_o),
    .rvalid_o (rvalid_o)
  );

endmodule

/* tb/tb_dcache_lsu.sv */
`timescale 1ns/10ps

module tb_dcache_lsu
  import dcache_pkg::*;
();

  localparam int num_rand      = 300;
  localparam int num_ops       = num_rand + 14;
  localparam int timeout_cycles = num_ops * 20 + 50;

  logic        clk;
  logic        rst_n;
  logic        req_valid_i;
  lsu_op_e     req_op_i;
  logic [31:0] req_addr_i;
  logic [31:0] req_wdata_i;
  logic [3:0]  req_strobe_i;
  load_type_e  req_type_i;
  logic        busy_o;
  logic [31:0] rdata_o;
  logic        rvalid_o;
  logic        psel_o;
  logic        penable_o;
  logic        pwrite_o;
  logic [31:0] paddr_o;
  logic [31:0] pwdata_o;
  logic [3:0]  pstrb_o;
  logic [31:0] prdata_i;
  logic        pready_i;
  logic        pslverr_i;

  // reference state, word addressed
  logic [31:0] model_mem [logic [29:0]];
  logic [31:0] bus_mem [logic [29:0]];
  logic        tag_valid [2][64];
  logic [23:0] tag_val [2][64];
  logic        victim;
  logic        prev_slow;

  // expected results and bus transfers, in order
  logic [31:0] exp_data_q [$];
  int          exp_cycle_q [$];
  logic        exp_timed_q [$];
  logic [31:0] exp_paddr_q [$];
  logic        exp_pwrite_q [$];
  logic [31:0] exp_pwdata_q [$];
  logic [3:0]  exp_pstrb_q [$];

  logic [31:0] stim_lfsr;
  logic [31:0] wait_lfsr;
  logic [1:0]  wait_cnt;
  int          cycle;
  int          bus_count;
  int          chk_main;
  int          err_main;
  int          chk_mon;
  int          err_mon;
  int          tests;

  dcache_lsu u_dcache_lsu (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_strobe_i (req_strobe_i),
    .req_type_i   (req_type_i),
    .busy_o       (busy_o),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .pwrite_o     (pwrite_o),
    .paddr_o      (paddr_o),
    .pwdata_o     (pwdata_o),
    .pstrb_o      (pstrb_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .pslverr_i    (pslverr_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycle = 0;
    forever begin
      @(posedge clk);
      cycle++;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("watchdog expired before all requests completed");
    $display("Testbench failed");
    $finish;
  end

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r  = {r[30:0], st[0]};
      st = st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
    end
    return r;
  endfunction

  // initial memory contents depend on every address bit
  function automatic logic [31:0] fill_word(input logic [29:0] wa);
    logic [31:0] a;
    a = {wa, 2'b00};
    return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_a5c3;
  endfunction

  function automatic logic [31:0] model_read(input logic [29:0] wa);
    return model_mem.exists(wa) ? model_mem[wa] : fill_word(wa);
  endfunction

  function automatic logic [31:0] bus_read(input logic [29:0] wa);
    return bus_mem.exists(wa) ? bus_mem[wa] : fill_word(wa);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  // little endian byte and halfword pick, then extension
  function automatic logic [31:0] expect_load(input logic [31:0] w, input logic [1:0] off,
                                              input load_type_e lt);
    logic [7:0]  b;
    logic [15:0] h;
    case (off)
      2'd0:    b = w[7:0];
      2'd1:    b = w[15:8];
      2'd2:    b = w[23:16];
      default: b = w[31:24];
    endcase
    h = off[1] ? w[31:16] : w[15:0];
    case (lt)
      LT_LB:   return {{24{b[7]}}, b};
      LT_LBU:  return {24'h0, b};
      LT_LH:   return {{16{h[15]}}, h};
      LT_LHU:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // drive on the falling edge, hold until busy_o is low
  task automatic issue(input lsu_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
                       input logic [3:0] strb, input load_type_e lt);
    logic [5:0]  idx;
    logic [23:0] tag;
    logic        unc;
    logic        hit;
    idx = addr[7:2];
    tag = addr[31:8];
    unc = addr[31];
    @(negedge clk);
    req_valid_i  = 1'b1;
    req_op_i     = op;
    req_addr_i   = addr;
    req_wdata_i  = wdata;
    req_strobe_i = strb;
    req_type_i   = lt;
    while (busy_o) @(negedge clk);
    // taken on the coming rising edge
    hit = !unc && ((tag_valid[0][idx] && tag_val[0][idx] == tag) ||
                   (tag_valid[1][idx] && tag_val[1][idx] == tag));
    case (op)
      OP_LOAD: begin
        exp_data_q.push_back(expect_load(model_read(addr[31:2]), addr[1:0], lt));
        exp_cycle_q.push_back(cycle + 2);
        exp_timed_q.push_back(hit && !prev_slow);
        if (!hit) begin
          exp_paddr_q.push_back(unc ? addr : {addr[31:2], 2'b00});
          exp_pwrite_q.push_back(1'b0);
          exp_pwdata_q.push_back(32'h0);
          exp_pstrb_q.push_back(4'h0);
          if (!unc) begin
            tag_valid[victim][idx] = 1'b1;
            tag_val[victim][idx]   = tag;
            victim = !victim;
          end
        end
        prev_slow = !hit;
      end
      OP_STORE: begin
        model_mem[addr[31:2]] = merge_bytes(model_read(addr[31:2]), wdata, strb);
        exp_paddr_q.push_back(addr);
        exp_pwrite_q.push_back(1'b1);
        exp_pwdata_q.push_back(wdata);
        exp_pstrb_q.push_back(strb);
        prev_slow = 1'b1;
      end
      OP_INV: begin
        tag_valid[0][idx] = 1'b0;
        tag_valid[1][idx] = 1'b0;
        prev_slow = 1'b1;
      end
      default: prev_slow = 1'b0;
    endcase
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    req_valid_i = 1'b0;
  endtask

  task automatic drain();
    idle_cycle();
    while (exp_data_q.size() != 0 || exp_paddr_q.size() != 0 || busy_o) begin
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
  endtask

  task automatic random_request();
    logic [31:0] r;
    logic [31:0] wdata;
    logic [31:0] strb;
    logic [23:0] tag;
    logic [5:0]  idx;
    logic [1:0]  off;
    lsu_op_e     op;
    load_type_e  lt;
    r = take_bits(stim_lfsr, 3);
    if (r[2:0] == 3'd7) begin
      idle_cycle();
      return;
    end
    op = (r[2:0] < 3'd4) ? OP_LOAD : ((r[2:0] == 3'd6) ? OP_INV : OP_STORE);
    r = take_bits(stim_lfsr, 2);
    tag = 24'h31 + {22'h0, r[1:0]};
    r = take_bits(stim_lfsr, 2);
    idx = {r[1:0], 4'h5};
    r = take_bits(stim_lfsr, 3);
    if (r[2:0] == 3'd0) begin
      tag = 24'h80_0055;
    end
    r = take_bits(stim_lfsr, 3);
    lt = (r[2:0] > 3'd4) ? LT_LW : load_type_e'(r[2:0]);
    r = take_bits(stim_lfsr, 2);
    off = r[1:0];
    if (lt == LT_LW) begin
      off = 2'b00;
    end else if (lt == LT_LH || lt == LT_LHU) begin
      off[0] = 1'b0;
    end
    wdata = take_bits(stim_lfsr, 32);
    strb  = take_bits(stim_lfsr, 4);
    issue(op, {tag, idx, off}, wdata, strb[3:0], lt);
  endtask

  task automatic report(input string name, input int err_start);
    tests++;
    $display("test %s: %0d errors", name, err_main + err_mon - err_start);
  endtask

  task automatic check_result();
    logic [31:0] ed;
    int          ec;
    logic        timed;
    chk_mon++;
    assert (exp_data_q.size() > 0) else begin
      $display("load result appeared with no load outstanding");
      err_mon++;
    end
    if (exp_data_q.size() > 0) begin
      ed    = exp_data_q.pop_front();
      ec    = exp_cycle_q.pop_front();
      timed = exp_timed_q.pop_front();
      assert (rdata_o == ed) else begin
        $display("FAILED rdata_o expected %h got %h", ed, rdata_o);
        err_mon++;
      end
      if (timed) begin
        assert (cycle == ec) else begin
          $display("hit result came at cycle %0d, expected cycle %0d", cycle, ec);
          err_mon++;
        end
      end
    end
  endtask

  task automatic finish_transfer();
    logic [31:0] ea;
    logic        ew;
    logic [31:0] ewd;
    logic [3:0]  es;
    chk_mon++;
    bus_count++;
    assert (exp_paddr_q.size() > 0) else begin
      $display("APB transfer to %h with none expected", paddr_o);
      err_mon++;
    end
    if (exp_paddr_q.size() > 0) begin
      ea  = exp_paddr_q.pop_front();
      ew  = exp_pwrite_q.pop_front();
      ewd = exp_pwdata_q.pop_front();
      es  = exp_pstrb_q.pop_front();
      assert (paddr_o == ea) else begin
        $display("FAILED paddr_o expected %h got %h", ea, paddr_o);
        err_mon++;
      end
      assert (pwrite_o == ew) else begin
        $display("FAILED pwrite_o expected %h got %h", ew, pwrite_o);
        err_mon++;
      end
      assert (pstrb_o == es) else begin
        $display("FAILED pstrb_o expected %h got %h", es, pstrb_o);
        err_mon++;
      end
      if (ew) begin
        assert (pwdata_o == ewd) else begin
          $display("FAILED pwdata_o expected %h got %h", ewd, pwdata_o);
          err_mon++;
        end
      end
    end
    if (pwrite_o) begin
      bus_mem[paddr_o[31:2]] = merge_bytes(bus_read(paddr_o[31:2]), pwdata_o, pstrb_o);
    end
  endtask

  // result monitor and APB slave with 0 to 3 wait states
  initial begin
    logic [31:0] r;
    pready_i  = 1'b0;
    prdata_i  = '0;
    pslverr_i = 1'b0;
    wait_lfsr = 32'hf4df;
    wait_cnt  = '0;
    forever begin
      @(negedge clk);
      if (rst_n && rvalid_o) begin
        check_result();
      end
      if (rst_n && psel_o && !penable_o) begin
        r        = take_bits(wait_lfsr, 2);
        wait_cnt = r[1:0];
        pready_i = 1'b0;
        prdata_i = bus_read(paddr_o[31:2]);
      end else if (rst_n && psel_o && penable_o) begin
        if (wait_cnt == 2'd0) begin
          // access completes on the coming rising edge
          pready_i = 1'b1;
          finish_transfer();
        end else begin
          wait_cnt = wait_cnt - 2'd1;
          pready_i = 1'b0;
        end
      end else begin
        pready_i = 1'b0;
      end
    end
  end

  initial begin
    int start;
    int bus_before;
    rst_n        = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = OP_NOP;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    req_strobe_i = '0;
    req_type_i   = LT_LW;
    stim_lfsr    = 32'hf4df;
    victim       = 1'b0;
    prev_slow    = 1'b0;
    bus_count    = 0;
    chk_main     = 0;
    err_main     = 0;
    chk_mon      = 0;
    err_mon      = 0;
    tests        = 0;
    for (int w = 0; w < 2; w++) begin
      for (int i = 0; i < 64; i++) begin
        tag_valid[w][i] = 1'b0;
        tag_val[w][i]   = '0;
      end
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    start = err_main + err_mon;
    repeat (3) begin
      @(negedge clk);
      chk_main++;
      assert (!busy_o && !rvalid_o && !psel_o && !penable_o) else begin
        $display("FAILED busy_o %h rvalid_o %h psel_o %h penable_o %h after reset",
                 busy_o, rvalid_o, psel_o, penable_o);
        err_main++;
      end
    end
    report("reset", start);

    // store then load of the same word, resident and not resident
    start = err_main + err_mon;
    issue(OP_LOAD, 32'h0000_1234, 32'h0, 4'h0, LT_LW);
    issue(OP_STORE, 32'h0000_1234, 32'ha5c3_5a7e, 4'b0110, LT_LW);
    issue(OP_LOAD, 32'h0000_1234, 32'h0, 4'h0, LT_LW);
    issue(OP_LOAD, 32'h0000_1235, 32'h0, 4'h0, LT_LB);
    issue(OP_STORE, 32'h0000_3318, 32'h1122_3344, 4'hf, LT_LW);
    issue(OP_LOAD, 32'h0000_331a, 32'h0, 4'h0, LT_LH);
    drain();
    report("store_forward", start);

    // resident word, then invalidate, then miss again
    start = err_main + err_mon;
    issue(OP_LOAD, 32'h0000_2240, 32'h0, 4'h0, LT_LW);
    issue(OP_LOAD, 32'h0000_2241, 32'h0, 4'h0, LT_LBU);
    issue(OP_INV, 32'h0000_2240, 32'h0, 4'h0, LT_LW);
    drain();
    bus_before = bus_count;
    issue(OP_LOAD, 32'h0000_2242, 32'h0, 4'h0, LT_LHU);
    drain();
    chk_main++;
    assert (bus_count == bus_before + 1) else begin
      $display("load after invalidate made %0d APB transfers instead of one",
               bus_count - bus_before);
      err_main++;
    end
    report("invalidate", start);

    start = err_main + err_mon;
    for (int i = 0; i < num_rand; i++) begin
      random_request();
    end
    drain();
    chk_main++;
    assert (exp_data_q.size() == 0 && exp_paddr_q.size() == 0) else begin
      $display("%0d load results and %0d APB transfers never arrived",
               exp_data_q.size(), exp_paddr_q.size());
      err_main++;
    end
    report("random", start);

    $display("tests %0d, checks %0d, errors %0d", tests, chk_main + chk_mon,
             err_main + err_mon);
    if (err_main + err_mon == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* dcache_lsu.f */
+incdir+include
source/dcache_pkg.sv
source/load_align.sv
source/dcache_lookup.sv
source/dcache_miss_ctrl.sv
source/dcache_lsu.sv
tb/tb_dcache_lsu.sv

/* run.sh */
#!/bin/sh
# builds and runs the dcache_lsu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f dcache_lsu.f --top-module tb_dcache_lsu -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# exit status comes from the search
echo "$out" | grep -q "^Testbench passed$"
